// ==== logic/emesh_consts.svh ====
`ifndef EMESH_CONSTS_SVH
`define EMESH_CONSTS_SVH

// mesh packet width in bits
// write, datamode, ctrlmode, dstaddr, data, srcaddr
`define EMESH_PW 104

// chip id of this node, compared against dstaddr[31:20]
`define EMESH_ID 12'h999

// address groups, taken from dstaddr[19:16]

// memory mapped registers
`define EGROUP_MMR 4'hF

// translation table
`define EGROUP_MMU 4'hE

// read response traffic
`define EGROUP_RR 4'hB

// bank sizes, in entries
`define CFG_DEPTH 8

`define DMA_DEPTH 8

`define MMU_DEPTH 16

`endif

// ==== logic/emesh_pkg.sv ====
package emesh_pkg;

   // mesh address, chip id sits in the top 12 bits
   typedef logic [31:0] addr_t;

   // one data word of a packet
   typedef logic [31:0] word_t;

   // transfer size code
   typedef logic [1:0] datamode_t;

   // routing and special mode bits
   typedef logic [4:0] ctrlmode_t;

   // register bus address, low bits of dstaddr
   typedef logic [14:0] mi_addr_t;

   // register bus data
   // srcaddr in the upper word, data in the lower word
   typedef logic [63:0] mi_data_t;

   // one translation table entry
   typedef logic [63:0] mmu_entry_t;

endpackage

// ==== logic/mi_regbank.sv ====
module mi_regbank
   import emesh_pkg::*;
#(
   parameter int  DEPTH   = 8,
   parameter int  LSB     = 2,
   parameter type entry_t = word_t
)
(
   input  logic     clk,
   input  logic     nreset,
   input  logic     en,
   input  logic     we,
   input  mi_addr_t mi_addr,
   input  mi_data_t mi_din,
   output mi_data_t mi_dout
);

   // index bits needed to cover DEPTH entries
   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   entry_t             mem [DEPTH];
   logic [IDX_W-1:0]   idx;
   logic               wr_en;
   logic               rd_en;

   assign idx   = mi_addr[LSB +: IDX_W];
   assign wr_en = en & we;
   assign rd_en = en & ~we;

   // entries start cleared so early reads return zero
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         // keep only as many low bits as the entry holds
         mem[idx] <= entry_t'(mi_din);
      end
   end

   // readback holds until the next read of this bank
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mi_dout <= '0;
      end
      else if (rd_en)
      begin
         // narrow entries come back zero extended
         mi_dout <= mi_data_t'(mem[idx]);
      end
   end

   // decoded address must land inside the bank
   a_idx_range: assert property (
      @(posedge clk) disable iff (!nreset)
      en |-> (int'(idx) < DEPTH)
   );

endmodule

// ==== logic/ecfg_if.sv ====
`include "emesh_consts.svh"

module ecfg_if
   import emesh_pkg::*;
#(
   parameter int RX = 0
)
(
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 access_in,
   input  logic [`EMESH_PW-1:0] packet_in,
   input  logic                 wait_in,
   input  mi_data_t             mi_dout_cfg,
   input  mi_data_t             mi_dout_dma,
   input  mi_data_t             mi_dout_mmu,
   output logic                 mi_cfg_en,
   output logic                 mi_dma_en,
   output logic                 mi_mmu_en,
   output logic                 mi_we,
   output mi_addr_t             mi_addr,
   output mi_data_t             mi_din,
   output logic                 access_out,
   output logic [`EMESH_PW-1:0] packet_out
);

   // selects which half of the shared map this instance answers
   localparam logic RX_SEL = RX[0];

   logic                 write;
   datamode_t            datamode;
   ctrlmode_t            ctrlmode;
   addr_t                dstaddr;
   word_t                data;
   addr_t                srcaddr;
   logic [3:0]           group;

   logic                 id_match;
   logic                 cfg_sel;
   logic                 dma_sel;
   logic                 mmu_sel;
   logic                 bank_sel;
   logic                 fwd_sel;
   logic                 rd_req;

   logic [2:0]           rd_bank;
   logic                 write_q;
   datamode_t            datamode_q;
   ctrlmode_t            ctrlmode_q;
   addr_t                dstaddr_q;
   addr_t                srcaddr_q;
   word_t                data_q;

   mi_data_t             readback;
   logic                 rd_valid;
   addr_t                srcaddr_out;
   word_t                data_out;

   // packet fields, bit 0 upward
   assign write    = packet_in[0];
   assign datamode = packet_in[2:1];
   assign ctrlmode = packet_in[7:3];
   assign dstaddr  = packet_in[39:8];
   assign data     = packet_in[71:40];
   assign srcaddr  = packet_in[`EMESH_PW-1:72];

   assign group = dstaddr[19:16];

   // chip id match qualifies every decode
   assign id_match = access_in & (dstaddr[31:20] == `EMESH_ID);

   // config registers, 0x2xx for tx and 0x3xx for rx
   assign cfg_sel = id_match &
                    (group == `EGROUP_MMR) &
                    (dstaddr[10:8] == {2'b01, RX_SEL});

   // dma descriptors live at 0x5xx, bit 5 picks the half
   assign dma_sel = id_match &
                    (group == `EGROUP_MMR) &
                    (dstaddr[10:8] == 3'h5) &
                    (dstaddr[5] == RX_SEL);

   assign mmu_sel = id_match &
                    (group == `EGROUP_MMU) &
                    (dstaddr[15] == RX_SEL);

   assign bank_sel = cfg_sel | dma_sel | mmu_sel;
   assign rd_req   = bank_sel & ~write;

   // register traffic for the partner block passes through
   assign fwd_sel = id_match &
                    ~bank_sel &
                    ((group == `EGROUP_RR) |
                     (group == `EGROUP_MMR) |
                     (group == `EGROUP_MMU));

   // no bank activity while downstream is stalled
   assign mi_cfg_en = cfg_sel & ~wait_in;
   assign mi_dma_en = dma_sel & ~wait_in;
   assign mi_mmu_en = mmu_sel & ~wait_in;

   assign mi_we   = write & (mi_cfg_en | mi_dma_en | mi_mmu_en);
   assign mi_addr = dstaddr[14:0];
   assign mi_din  = {srcaddr, data};

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_out <= 1'b0;
         rd_bank    <= 3'b000;
      end
      else if (!wait_in)
      begin
         access_out <= fwd_sel | rd_req;
         // remembers which bank owns next cycle's readback
         rd_bank    <= {mmu_sel, dma_sel, cfg_sel} & {3{~write}};
      end
   end

   // response fields, held during a stall
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         write_q    <= fwd_sel ? write : 1'b1;
         datamode_q <= datamode;
         ctrlmode_q <= fwd_sel ? {1'b0, ctrlmode[3:0]} : ctrlmode;
         // a read answers back to the requester
         dstaddr_q  <= fwd_sel ? dstaddr : srcaddr;
         srcaddr_q  <= srcaddr;
         data_q     <= data;
      end
   end

   // one-hot select of the bank that was read
   assign readback = ({64{rd_bank[0]}} & mi_dout_cfg) |
                     ({64{rd_bank[1]}} & mi_dout_dma) |
                     ({64{rd_bank[2]}} & mi_dout_mmu);

   assign rd_valid = |rd_bank;

   assign srcaddr_out = rd_valid ? readback[63:32] : srcaddr_q;
   assign data_out    = rd_valid ? readback[31:0]  : data_q;

   assign packet_out = {srcaddr_out,
                        data_out,
                        dstaddr_q,
                        ctrlmode_q,
                        datamode_q,
                        write_q};

   // banks must never see overlapping enables
   a_onehot_en: assert property (
      @(posedge clk) disable iff (!nreset)
      $onehot0({mi_cfg_en, mi_dma_en, mi_mmu_en})
   );

   // a stall freezes the response, including the bank readback path
   a_stall_hold: assert property (
      @(posedge clk) disable iff (!nreset)
      $past(wait_in) |-> ($stable(access_out) && $stable(packet_out))
   );

endmodule

// ==== logic/ecfg_top.sv ====
`include "emesh_consts.svh"

module ecfg_top
   import emesh_pkg::*;
#(
   parameter int RX = 0
)
(
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 access_in,
   input  logic [`EMESH_PW-1:0] packet_in,
   input  logic                 wait_in,
   output logic                 access_out,
   output logic [`EMESH_PW-1:0] packet_out
);

   logic     mi_cfg_en;
   logic     mi_dma_en;
   logic     mi_mmu_en;
   logic     mi_we;
   mi_addr_t mi_addr;
   mi_data_t mi_din;
   mi_data_t mi_dout_cfg;
   mi_data_t mi_dout_dma;
   mi_data_t mi_dout_mmu;

   ecfg_if #(
      .RX (RX)
   ) u_ecfg_if (
      .clk         (clk),
      .nreset      (nreset),
      .access_in   (access_in),
      .packet_in   (packet_in),
      .wait_in     (wait_in),
      .mi_dout_cfg (mi_dout_cfg),
      .mi_dout_dma (mi_dout_dma),
      .mi_dout_mmu (mi_dout_mmu),
      .mi_cfg_en   (mi_cfg_en),
      .mi_dma_en   (mi_dma_en),
      .mi_mmu_en   (mi_mmu_en),
      .mi_we       (mi_we),
      .mi_addr     (mi_addr),
      .mi_din      (mi_din),
      .access_out  (access_out),
      .packet_out  (packet_out)
   );

   // word wide config registers
   mi_regbank #(
      .DEPTH   (`CFG_DEPTH),
      .LSB     (2),
      .entry_t (word_t)
   ) cfg_bank (
      .clk     (clk),
      .nreset  (nreset),
      .en      (mi_cfg_en),
      .we      (mi_we),
      .mi_addr (mi_addr),
      .mi_din  (mi_din),
      .mi_dout (mi_dout_cfg)
   );

   // dma descriptor words
   mi_regbank #(
      .DEPTH   (`DMA_DEPTH),
      .LSB     (2),
      .entry_t (word_t)
   ) dma_bank (
      .clk     (clk),
      .nreset  (nreset),
      .en      (mi_dma_en),
      .we      (mi_we),
      .mi_addr (mi_addr),
      .mi_din  (mi_din),
      .mi_dout (mi_dout_dma)
   );

   // translation table, 8 byte stride
   mi_regbank #(
      .DEPTH   (`MMU_DEPTH),
      .LSB     (3),
      .entry_t (mmu_entry_t)
   ) mmu_bank (
      .clk     (clk),
      .nreset  (nreset),
      .en      (mi_mmu_en),
      .we      (mi_we),
      .mi_addr (mi_addr),
      .mi_din  (mi_din),
      .mi_dout (mi_dout_mmu)
   );

endmodule

// ==== sim/ecfg_tb.sv ====
`include "emesh_consts.svh"

module ecfg_tb
   import emesh_pkg::*;
();

   localparam int RESET_LIMIT = 20;
   localparam int LINE_LIMIT  = 500;
   localparam int PW          = `EMESH_PW;

   logic          clk;
   logic          nreset;
   logic          access_in;
   logic [PW-1:0] packet_in;
   logic          wait_in;
   logic          access_out;
   logic [PW-1:0] packet_out;

   int            fd;
   int            line_no;
   int            fields;
   int            cycles;
   int unsigned   stall_len;
   string         line;
   logic [3:0]    acc_f;
   logic [PW-1:0] pkt_f;
   logic [3:0]    flag_f;
   logic [3:0]    exp_acc_f;
   logic [PW-1:0] exp_pkt_f;

   // expectations of the line presented last
   logic          pend;
   int            pend_line;
   logic          pend_flag;
   logic          pend_acc;
   logic [PW-1:0] pend_pkt;

   // outputs frozen by a stall
   logic          held_acc;
   logic [PW-1:0] held_pkt;

   ecfg_top #(
      .RX (0)
   ) UUT (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #5 clk = ~clk;

   initial
   begin
      clk    = 1'b0;
      nreset = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      nreset = 1'b1;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input logic [PW-1:0] expected, input logic [PW-1:0] actual,
                              input string what);
      if (actual !== expected)
      begin
         $display("FAILED at %0t: %s, expected %h, got %h", $time, what, expected, actual);
         $display("TB FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic check_response();
      addr_t resp_dst;
      resp_dst = pend_pkt[39:8];
      check_value(PW'(pend_acc), PW'(access_out), $sformatf("line %0d access_out", pend_line));
      if (pend_flag)
      begin
         check_value(pend_pkt, packet_out,
                     $sformatf("line %0d packet_out to %h", pend_line, resp_dst));
      end
   endtask

   // hold the presented packet while downstream waits
   task automatic stall_cycles(input int unsigned len);
      held_acc = access_out;
      held_pkt = packet_out;
      wait_in  = 1'b1;
      for (int unsigned i = 0; i < len; i++)
      begin
         @(posedge clk);
         #1;
         check_value(PW'(held_acc), PW'(access_out), "access_out moved during stall");
         check_value(held_pkt, packet_out, "packet_out moved during stall");
      end
      wait_in = 1'b0;
   endtask

   initial
   begin
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      pend      = 1'b0;
      void'($urandom(52399));

      cycles = 0;
      while (nreset !== 1'b1 && cycles < RESET_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (nreset !== 1'b1)
         abort_run("reset was never released");
      check_value('0, PW'(access_out), "access_out after reset");

      fd = $fopen("sim/ecfg_testdata.txt", "r");
      if (fd == 0)
         abort_run("could not open sim/ecfg_testdata.txt");

      line_no = 0;
      while (!$feof(fd) && line_no < LINE_LIMIT)
      begin
         line_no++;
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         fields = $sscanf(line, "%h %h %h %h %h", acc_f, pkt_f, flag_f, exp_acc_f, exp_pkt_f);
         if (fields != 5)
            abort_run($sformatf("line %0d of the data file could not be parsed", line_no));
         @(posedge clk);
         #1;
         // answer to the previous line is visible one cycle after it was sampled
         if (pend)
            check_response();
         access_in = acc_f[0];
         packet_in = pkt_f;
         pend      = 1'b1;
         pend_line = line_no;
         pend_flag = flag_f[0];
         pend_acc  = exp_acc_f[0];
         pend_pkt  = exp_pkt_f;
         stall_len = ($urandom % 3 == 0) ? 1 + ($urandom % 3) : 0;
         if (stall_len > 0)
            stall_cycles(stall_len);
      end
      if (line_no >= LINE_LIMIT && !$feof(fd))
         abort_run("data file did not end within the line limit");
      $fclose(fd);

      @(posedge clk);
      #1;
      if (pend)
         check_response();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== sim/ecfg_testdata.txt ====
# access_in packet_in check_packet exp_access_out exp_packet_out, all hex
# packet = srcaddr data dstaddr {ctrlmode,datamode,write}
# reads straight after reset
1 8100004000000000999F020004 1 1 00000000000000008100004005
1 8100004000000000999F050404 1 1 00000000000000008100004005
1 8100004000000000999E001004 1 1 00000000000000008100004005
# bank writes, then readback
1 CAFE000112345678999F020405 0 0 00000000000000000000000000
1 0BAD0000A5A5F00F999F021C05 0 0 00000000000000000000000000
1 11112222DEADBEEF999F050005 0 0 00000000000000000000000000
1 3333444400C0FFEE999F051C05 0 0 00000000000000000000000000
1 0123456789ABCDEF999E001005 0 0 00000000000000000000000000
1 FEDCBA9855AA55AA999E007805 0 0 00000000000000000000000000
1 8100004000000000999F020404 1 1 00000000123456788100004005
1 8200008000000000999F021C96 1 1 00000000A5A5F00F8200008097
1 8100004000000000999F050004 1 1 00000000DEADBEEF8100004005
1 8100004000000000999F051C04 1 1 0000000000C0FFEE8100004005
1 8100004000000000999E001004 1 1 0123456789ABCDEF8100004005
1 8100004000000000999E007804 1 1 FEDCBA9855AA55AA8100004005
# forwarded, rx half included
1 808000000000ABCD999B1234FD 1 1 808000000000ABCD999B12347D
1 8100004000000000999F040004 1 1 8100004000000000999F040004
1 8100004077777777999F030405 1 1 8100004077777777999F030405
1 8100004000000000999F052080 1 1 8100004000000000999F052000
1 246813570F0F0F0F999E800823 1 1 246813570F0F0F0F999E800823
1 8100004000000000999F020404 1 1 00000000123456788100004005
1 8100004000000000999E000804 1 1 00000000000000008100004005
# dropped packets
1 8100004000000000998F020404 0 0 00000000000000000000000000
1 8100004099999999123F020005 0 0 00000000000000000000000000
1 81000040000000009993000004 0 0 00000000000000000000000000
1 8100004000000000999F020004 1 1 00000000000000008100004005
0 8100004000000000999F020404 0 0 00000000000000000000000000
1 000000010BADF00D999F020405 0 0 00000000000000000000000000
1 8100004000000000999F020404 1 1 000000000BADF00D8100004005
1 2468ACE013579BDF999F050C05 0 0 00000000000000000000000000
1 8100004000000000999F050C04 1 1 0000000013579BDF8100004005
0 00000000000000000000000000 0 0 00000000000000000000000000

// ==== vlog.f ====
+incdir+logic
logic/emesh_pkg.sv
logic/mi_regbank.sv
logic/ecfg_if.sv
logic/ecfg_top.sv
sim/ecfg_tb.sv

// ==== Bender.yml ====
package:
  name: ecfg

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/emesh_pkg.sv
      - logic/mi_regbank.sv
      - logic/ecfg_if.sv
      - logic/ecfg_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/ecfg_tb.sv
